//--- common/mem_pkg.sv
package mem_pkg;

    // byte address width shared by caches, arbiter and burst memory
    localparam int ADDR_W = 32;

    // one cache line and one burst beat
    localparam int LINE_W = 256;
    localparam int BEAT_W = 64;
    localparam int BEATS = LINE_W / BEAT_W;

    // beat counter inside the adapter
    localparam int BEAT_CNT_W = $clog2(BEATS);
    localparam logic [BEAT_CNT_W-1:0] LAST_BEAT = BEAT_CNT_W'(BEATS - 1);

    // line request, from a cache or from the arbiter to the adapter
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              read;
        logic              write;
        logic [LINE_W-1:0] wdata;
    } line_req_t;

    // line response, resp is a single-cycle pulse
    typedef struct packed {
        logic [LINE_W-1:0] rdata;
        logic              resp;
    } line_rsp_t;

    // command side of the burst memory
    typedef struct packed {
        logic [ADDR_W-1:0] addr;
        logic              read;
        logic              write;
        logic [BEAT_W-1:0] wdata;
    } bmem_req_t;

    // return side of the burst memory
    // rvalid is independent of ready
    typedef struct packed {
        logic [BEAT_W-1:0] rdata;
        logic              rvalid;
        logic              ready;
    } bmem_rsp_t;

endpackage : mem_pkg

//--- arbiter/cache_arbiter.sv
module cache_arbiter
(
    input  logic                clk,
    input  logic                rst,

    // instruction cache side, read only
    input  mem_pkg::line_req_t  i_icache_req,
    output mem_pkg::line_rsp_t  o_icache_rsp,

    // data cache side
    input  mem_pkg::line_req_t  i_dcache_req,
    output mem_pkg::line_rsp_t  o_dcache_rsp,

    // line port towards the cacheline adapter
    output mem_pkg::line_req_t  o_line_req,
    output logic                o_line_start,
    input  mem_pkg::line_rsp_t  i_line_rsp
);

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_INST,
        ARB_DATA
    } arb_state_t;

    arb_state_t state_q;
    arb_state_t state_d;

    // granted request, held stable until the adapter is done
    mem_pkg::line_req_t req_q;
    mem_pkg::line_req_t req_d;

    logic start_q;
    logic start_d;

    logic icache_wait;
    logic dcache_wait;
    logic line_done;

    assign icache_wait = i_icache_req.read;
    assign dcache_wait = i_dcache_req.read | i_dcache_req.write;
    assign line_done = i_line_rsp.resp;

    // next grant
    // the owner still holds its request in the done cycle,
    // so only the other cache is looked at on completion
    always_comb
    begin
        state_d = state_q;
        req_d = req_q;
        start_d = 1'b0;

        case (state_q)
            ARB_IDLE:
            begin
                // data wins when both are waiting
                if (dcache_wait)
                begin
                    state_d = ARB_DATA;
                    req_d = i_dcache_req;
                    start_d = 1'b1;
                end
                else if (icache_wait)
                begin
                    state_d = ARB_INST;
                    req_d.addr = i_icache_req.addr;
                    req_d.read = 1'b1;
                    req_d.write = 1'b0;
                    req_d.wdata = '0;
                    start_d = 1'b1;
                end
            end

            ARB_INST:
            begin
                if (line_done)
                begin
                    if (dcache_wait)
                    begin
                        state_d = ARB_DATA;
                        req_d = i_dcache_req;
                        start_d = 1'b1;
                    end
                    else
                    begin
                        state_d = ARB_IDLE;
                    end
                end
            end

            ARB_DATA:
            begin
                if (line_done)
                begin
                    // an instruction miss that came in meanwhile goes next
                    if (icache_wait)
                    begin
                        state_d = ARB_INST;
                        req_d.addr = i_icache_req.addr;
                        req_d.read = 1'b1;
                        req_d.write = 1'b0;
                        req_d.wdata = '0;
                        start_d = 1'b1;
                    end
                    else
                    begin
                        state_d = ARB_IDLE;
                    end
                end
            end

            default:
            begin
                state_d = ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= ARB_IDLE;
            start_q <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            start_q <= start_d;
        end
    end

    // request payload only changes on a grant
    always_ff @(posedge clk)
    begin
        req_q <= req_d;
    end

    assign o_line_req = req_q;
    assign o_line_start = start_q;

    // steer the done pulse and line to the owner, the other side sees zero
    always_comb
    begin
        o_icache_rsp = '0;
        o_dcache_rsp = '0;

        if (line_done)
        begin
            if (state_q == ARB_INST)
            begin
                o_icache_rsp.resp = 1'b1;
                o_icache_rsp.rdata = i_line_rsp.rdata;
            end
            else if (state_q == ARB_DATA)
            begin
                o_dcache_rsp.resp = 1'b1;
                o_dcache_rsp.rdata = i_line_rsp.rdata;
            end
        end
    end

endmodule : cache_arbiter

//--- logic/cacheline_adapter.sv
module cacheline_adapter
(
    input  logic                clk,
    input  logic                rst,

    // line port from the arbiter
    input  mem_pkg::line_req_t  i_line_req,
    input  logic                i_line_start,
    output mem_pkg::line_rsp_t  o_line_rsp,

    // burst memory port
    output mem_pkg::bmem_req_t  o_bmem_req,
    input  mem_pkg::bmem_rsp_t  i_bmem_rsp
);

    typedef enum logic [1:0] {
        AD_IDLE,
        AD_RD_CMD,
        AD_RD_BEATS,
        AD_WR_BEATS
    } ad_state_t;

    ad_state_t state_q;

    logic [mem_pkg::BEAT_CNT_W-1:0] beat_q;
    logic done_q;

    logic [mem_pkg::ADDR_W-1:0] addr_q;

    // holds the write line while it is sent, or gathers the read line
    logic [mem_pkg::LINE_W-1:0] line_q;

    logic take_line;
    logic rd_beat;
    logic wr_beat;
    logic last_beat;

    assign take_line = (state_q == AD_IDLE) && i_line_start;
    assign rd_beat = (state_q == AD_RD_BEATS) && i_bmem_rsp.rvalid;
    assign wr_beat = (state_q == AD_WR_BEATS) && i_bmem_rsp.ready;
    assign last_beat = (beat_q == mem_pkg::LAST_BEAT);

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state_q <= AD_IDLE;
            beat_q <= '0;
            done_q <= 1'b0;
        end
        else
        begin
            done_q <= 1'b0;

            case (state_q)
                AD_IDLE:
                begin
                    beat_q <= '0;
                    if (i_line_start && i_line_req.write)
                    begin
                        state_q <= AD_WR_BEATS;
                    end
                    else if (i_line_start && i_line_req.read)
                    begin
                        state_q <= AD_RD_CMD;
                    end
                end

                // a read is one command cycle, held until ready
                AD_RD_CMD:
                begin
                    if (i_bmem_rsp.ready)
                    begin
                        state_q <= AD_RD_BEATS;
                    end
                end

                AD_RD_BEATS:
                begin
                    if (rd_beat)
                    begin
                        beat_q <= beat_q + 1'b1;
                        if (last_beat)
                        begin
                            state_q <= AD_IDLE;
                            done_q <= 1'b1;
                        end
                    end
                end

                // counter only moves on an accepted beat
                AD_WR_BEATS:
                begin
                    if (wr_beat)
                    begin
                        beat_q <= beat_q + 1'b1;
                        if (last_beat)
                        begin
                            state_q <= AD_IDLE;
                            done_q <= 1'b1;
                        end
                    end
                end

                default:
                begin
                    state_q <= AD_IDLE;
                end
            endcase
        end
    end

    // both directions shift towards the low end, beat 0 first
    always_ff @(posedge clk)
    begin
        if (take_line)
        begin
            addr_q <= i_line_req.addr;
            line_q <= i_line_req.wdata;
        end
        else if (rd_beat)
        begin
            line_q <= {i_bmem_rsp.rdata, line_q[mem_pkg::LINE_W-1:mem_pkg::BEAT_W]};
        end
        else if (wr_beat)
        begin
            // rotate so the next beat lands in the low bits
            line_q <= {line_q[mem_pkg::BEAT_W-1:0], line_q[mem_pkg::LINE_W-1:mem_pkg::BEAT_W]};
        end
    end

    assign o_bmem_req.addr = addr_q;
    assign o_bmem_req.read = (state_q == AD_RD_CMD);
    assign o_bmem_req.write = (state_q == AD_WR_BEATS);
    assign o_bmem_req.wdata = line_q[mem_pkg::BEAT_W-1:0];

    assign o_line_rsp.resp = done_q;
    assign o_line_rsp.rdata = line_q;

endmodule : cacheline_adapter

//--- logic/mem_subsystem.sv
module mem_subsystem
(
    input  logic                clk,
    input  logic                rst,

    // cache miss ports
    input  mem_pkg::line_req_t  i_icache_req,
    output mem_pkg::line_rsp_t  o_icache_rsp,
    input  mem_pkg::line_req_t  i_dcache_req,
    output mem_pkg::line_rsp_t  o_dcache_rsp,

    // burst memory
    output mem_pkg::bmem_req_t  o_bmem_req,
    input  mem_pkg::bmem_rsp_t  i_bmem_rsp
);

    // one line in flight between arbiter and adapter
    mem_pkg::line_req_t line_req;
    mem_pkg::line_rsp_t line_rsp;
    logic line_start;

    cache_arbiter arbiter_i
    (
        .clk          (clk),
        .rst          (rst),
        .i_icache_req (i_icache_req),
        .o_icache_rsp (o_icache_rsp),
        .i_dcache_req (i_dcache_req),
        .o_dcache_rsp (o_dcache_rsp),
        .o_line_req   (line_req),
        .o_line_start (line_start),
        .i_line_rsp   (line_rsp)
    );

    cacheline_adapter adapter_i
    (
        .clk          (clk),
        .rst          (rst),
        .i_line_req   (line_req),
        .i_line_start (line_start),
        .o_line_rsp   (line_rsp),
        .o_bmem_req   (o_bmem_req),
        .i_bmem_rsp   (i_bmem_rsp)
    );

endmodule : mem_subsystem

//--- verif/burst_mem_model.sv
module burst_mem_model
(
    input  logic               clk,
    input  logic               rst,
    input  logic               i_stall_en,
    input  mem_pkg::bmem_req_t i_bmem_req,
    output mem_pkg::bmem_rsp_t o_bmem_rsp
);

    localparam int LINES = 256;
    localparam int RD_LATENCY = 3;

    // four beats per line, beat 0 holds the low line bits
    logic [63:0] mem [0:LINES*4-1];

    // last four accepted write beats, indexed by beat count
    logic [31:0] wr_addr_log [0:3];
    logic [63:0] wr_data_log [0:3];
    int wr_count;

    integer seed = 32'h2589;
    logic [31:0] rnd;
    logic [31:0] rd_addr;
    int rd_wait;
    int rd_left;

    // every 32-bit word holds its line address xor its word index
    initial
    begin
        for (int i = 0; i < LINES; i++)
        begin
            for (int b = 0; b < 4; b++)
            begin
                mem[10'(i*4 + b)] = {32'(i*32) ^ 32'(2*b + 1), 32'(i*32) ^ 32'(2*b)};
            end
        end
    end

    always @(posedge clk)
    begin
        rnd = $random(seed);
        if (rst)
        begin
            o_bmem_rsp <= '0;
            o_bmem_rsp.ready <= 1'b1;
            wr_count <= 0;
            rd_left <= 0;
            rd_wait <= 0;
        end
        else
        begin
            // roughly one cycle in four stalled
            o_bmem_rsp.ready <= !i_stall_en || (rnd[1:0] != 2'b00);
            o_bmem_rsp.rvalid <= 1'b0;
            if (i_bmem_req.read && o_bmem_rsp.ready)
            begin
                rd_addr <= i_bmem_req.addr;
                rd_wait <= RD_LATENCY - 2;
                rd_left <= 4;
            end
            else if (rd_left != 0)
            begin
                if (rd_wait != 0)
                begin
                    rd_wait <= rd_wait - 1;
                end
                else
                begin
                    o_bmem_rsp.rvalid <= 1'b1;
                    o_bmem_rsp.rdata <= mem[{rd_addr[12:5], 2'(4 - rd_left)}];
                    rd_left <= rd_left - 1;
                end
            end
            if (i_bmem_req.write && o_bmem_rsp.ready)
            begin
                mem[{i_bmem_req.addr[12:5], wr_count[1:0]}] <= i_bmem_req.wdata;
                wr_addr_log[wr_count[1:0]] <= i_bmem_req.addr;
                wr_data_log[wr_count[1:0]] <= i_bmem_req.wdata;
                wr_count <= wr_count + 1;
            end
        end
    end

endmodule : burst_mem_model

//--- verif/mem_subsystem_tb.sv
module mem_subsystem_tb;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 16;
    localparam int IDLE_CYCLES = 20;
    localparam int N_RAND_OPS = 20;
    // directed ops plus up to two line ops per random step
    localparam int LINE_OPS = 5 + 2 * N_RAND_OPS;
    localparam int OP_CYCLES = 110;
    localparam int WATCHDOG_TIME =
        (RESET_CYCLES + IDLE_CYCLES + LINE_OPS * OP_CYCLES) * CLK_PERIOD;

    logic clk;
    logic rst;
    logic stall_en;
    mem_pkg::line_req_t icache_req;
    mem_pkg::line_req_t dcache_req;
    mem_pkg::line_rsp_t icache_rsp;
    mem_pkg::line_rsp_t dcache_rsp;
    mem_pkg::bmem_req_t bmem_req;
    mem_pkg::bmem_rsp_t bmem_rsp;

    integer seed = 32'h2589;
    int errors = 0;

    // index 0 is the instruction side and 1 the data side
    int resp_cnt [2];
    int ops_done [2];
    logic [255:0] resp_data [2];
    bit resp_order [$];
    mem_pkg::line_req_t pend_req [2];
    int pend_cnt [2];
    int pend_wr;

    // written lines override the preload pattern
    logic [255:0] shadow [0:255];
    bit written [0:255];

    mem_subsystem dut_i
    (
        .clk          (clk),
        .rst          (rst),
        .i_icache_req (icache_req),
        .o_icache_rsp (icache_rsp),
        .i_dcache_req (dcache_req),
        .o_dcache_rsp (dcache_rsp),
        .o_bmem_req   (bmem_req),
        .i_bmem_rsp   (bmem_rsp)
    );

    burst_mem_model mem_model_i
    (
        .clk        (clk),
        .rst        (rst),
        .i_stall_en (stall_en),
        .i_bmem_req (bmem_req),
        .o_bmem_rsp (bmem_rsp)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial
    begin
        #(WATCHDOG_TIME);
        $display("timeout: run did not end within %0d time units, errors: %0d",
                 WATCHDOG_TIME, errors + 1);
        $display("ERRORS FOUND");
        $finish;
    end

    // outputs are sampled mid-cycle
    always @(negedge clk)
    begin
        if (!rst)
        begin
            if (icache_rsp.resp)
            begin
                resp_cnt[1'b0] = resp_cnt[1'b0] + 1;
                resp_data[1'b0] = icache_rsp.rdata;
                resp_order.push_back(1'b0);
            end
            if (dcache_rsp.resp)
            begin
                resp_cnt[1'b1] = resp_cnt[1'b1] + 1;
                resp_data[1'b1] = dcache_rsp.rdata;
                resp_order.push_back(1'b1);
            end
            if (!icache_rsp.resp && icache_rsp.rdata != '0)
            begin
                errors++;
                $display("mismatch o_icache_rsp.rdata: got %h expected 0", icache_rsp.rdata);
            end
            if (!dcache_rsp.resp && dcache_rsp.rdata != '0)
            begin
                errors++;
                $display("mismatch o_dcache_rsp.rdata: got %h expected 0", dcache_rsp.rdata);
            end
            if (bmem_req.read && bmem_req.write)
            begin
                errors++;
                $display("burst memory saw read and write in the same cycle");
            end
        end
    end

    function automatic logic [255:0] expected_line(input logic [31:0] addr);
        logic [255:0] line;
        for (int w = 0; w < 8; w++)
        begin
            line[w*32 +: 32] = {addr[31:5], 5'b0} ^ 32'(w);
        end
        if (written[addr[12:5]])
        begin
            line = shadow[addr[12:5]];
        end
        return line;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic start_op(input bit side, input bit is_write, input logic [7:0] idx);
        mem_pkg::line_req_t req;
        req.addr = {19'b0, idx, 5'b0};
        req.read = !is_write;
        req.write = is_write;
        req.wdata = '0;
        for (int w = 0; w < 8 && is_write; w++)
        begin
            req.wdata[w*32 +: 32] = $random(seed);
        end
        pend_req[side] = req;
        pend_cnt[side] = resp_cnt[side];
        pend_wr = mem_model_i.wr_count;
        if (side)
        begin
            dcache_req = req;
        end
        else
        begin
            icache_req = req;
        end
    endtask

    // wait for resp and drop the request in the next cycle
    // a repeated pulse would show up in the cycle after that
    task automatic finish_op(input bit side);
        mem_pkg::line_req_t req;
        logic [255:0] expect_line;
        logic [1:0] slot;
        req = pend_req[side];
        while (resp_cnt[side] == pend_cnt[side])
        begin
            @(posedge clk);
        end
        #1;
        if (side)
        begin
            dcache_req = '0;
        end
        else
        begin
            icache_req = '0;
        end
        next_cycle();
        ops_done[side]++;
        if (resp_cnt[side] != pend_cnt[side] + 1)
        begin
            errors++;
            $display("resp pulsed %0d times for one request", resp_cnt[side] - pend_cnt[side]);
        end
        if (req.write)
        begin
            if (mem_model_i.wr_count != pend_wr + 4)
            begin
                errors++;
                $display("burst memory took %0d write beats instead of 4",
                         mem_model_i.wr_count - pend_wr);
            end
            for (int k = 0; k < 4; k++)
            begin
                slot = 2'(pend_wr + k);
                if (mem_model_i.wr_addr_log[slot] != req.addr)
                begin
                    errors++;
                    $display("mismatch o_bmem_req.addr: got %h expected %h",
                             mem_model_i.wr_addr_log[slot], req.addr);
                end
                if (mem_model_i.wr_data_log[slot] != req.wdata[k*64 +: 64])
                begin
                    errors++;
                    $display("mismatch o_bmem_req.wdata: got %h expected %h",
                             mem_model_i.wr_data_log[slot], req.wdata[k*64 +: 64]);
                end
            end
            shadow[req.addr[12:5]] = req.wdata;
            written[req.addr[12:5]] = 1'b1;
        end
        else
        begin
            expect_line = expected_line(req.addr);
            if (resp_data[side] != expect_line)
            begin
                errors++;
                $display("mismatch %s: got %h expected %h",
                         side ? "o_dcache_rsp.rdata" : "o_icache_rsp.rdata",
                         resp_data[side], expect_line);
            end
        end
    endtask

    task automatic single_op(input bit side, input bit is_write, input logic [7:0] idx);
        next_cycle();
        start_op(side, is_write, idx);
        finish_op(side);
    endtask

    // both caches raise a request in the same cycle
    task automatic dual_op(input bit d_write, input logic [7:0] iidx, input logic [7:0] didx);
        next_cycle();
        start_op(1'b0, 1'b0, iidx);
        start_op(1'b1, d_write, didx);
        finish_op(1'b1);
        finish_op(1'b0);
        if (resp_order.size() < 2 || resp_order[$-1] != 1'b1 || resp_order[$] != 1'b0)
        begin
            errors++;
            $display("data resp did not come before instruction resp");
        end
    endtask

    task automatic idle_after_reset();
        repeat (IDLE_CYCLES)
        begin
            @(negedge clk);
            if (icache_rsp.resp || dcache_rsp.resp || bmem_req.read || bmem_req.write)
            begin
                errors++;
                $display("resp or burst memory command active with no request");
            end
        end
    endtask

    task automatic inst_read();
        int d0;
        d0 = resp_cnt[1'b1];
        single_op(1'b0, 1'b0, 8'h12);
        if (resp_cnt[1'b1] != d0)
        begin
            errors++;
            $display("data resp pulsed during an instruction read");
        end
    endtask

    task automatic write_then_read();
        logic [31:0] r;
        r = $random(seed);
        single_op(1'b1, 1'b1, r[7:0]);
        single_op(1'b1, 1'b0, r[7:0]);
    endtask

    task automatic mixed_ops_with_stalls();
        logic [31:0] r;
        stall_en = 1'b1;
        repeat (N_RAND_OPS)
        begin
            r = $random(seed);
            case (r[1:0])
                2'd0: single_op(1'b0, 1'b0, {4'h4, r[7:4]});
                2'd1: single_op(1'b1, 1'b0, {4'h4, r[7:4]});
                2'd2: single_op(1'b1, 1'b1, {4'h4, r[7:4]});
                default: dual_op(r[12], {4'h4, r[7:4]}, {4'h4, r[11:8]});
            endcase
        end
        stall_en = 1'b0;
    endtask

    initial
    begin
        rst = 1'b1;
        stall_en = 1'b0;
        icache_req = '0;
        dcache_req = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst = 1'b0;
        idle_after_reset();
        inst_read();
        write_then_read();
        dual_op(1'b0, 8'h21, 8'h33);
        mixed_ops_with_stalls();
        repeat (10) @(posedge clk);
        if (resp_cnt[1'b0] != ops_done[1'b0] || resp_cnt[1'b1] != ops_done[1'b1])
        begin
            errors++;
            $display("resp count differs from the number of requests");
        end
        $display("instruction ops: %0d, data ops: %0d, errors: %0d",
                 ops_done[1'b0], ops_done[1'b1], errors);
        if (errors == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule : mem_subsystem_tb

//--- flist.f
common/mem_pkg.sv
arbiter/cache_arbiter.sv
logic/cacheline_adapter.sv
logic/mem_subsystem.sv
verif/burst_mem_model.sv
verif/mem_subsystem_tb.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary
TOP   = mem_subsystem_tb
FLIST = flist.f

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir
